// ==== Bender.yml ====
package:
  name: uart_rx_subsystem

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_pkg.sv
      - logic/uart_rx_controller.sv
      - logic/uart_to_fifo_buf_fsm.sv
      - logic/uart_to_fifo_buf.sv
      - logic/fifo_buf.sv
      - logic/uart_rx_subsystem.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/uart_rx_chk.sv
      - dv/uart_rx_tb.sv

// ==== dv/uart_rx_chk.sv ====
`timescale 1ns/10ps

`include "uart_config.svh"

module uart_rx_chk (
	input logic clk,
	input logic reset,
	input uart_pkg::fifo_wr_t wr,
	input logic wr_rdy,
	input logic out_valid,
	input uart_pkg::credit_cnt_t credits,
	input uart_pkg::fifo_cnt_t count
);

	// Count of failed assertions
	int failures;

	// Write request only while the sequencer is free
	trigger_needs_rdy: assert property (@(posedge clk) disable iff (reset)
		wr.trigger |-> wr_rdy)
		else begin
			failures++;
			$error("write trigger raised while wr_rdy is low");
		end

	// No delivery without a credit in hand
	send_needs_credit: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> credits != '0)
		else begin
			failures++;
			$error("out_valid high with zero credits");
		end

	count_in_range: assert property (@(posedge clk) disable iff (reset)
		count <= uart_pkg::fifo_cnt_t'(`UART_FIFO_DEPTH))
		else begin
			failures++;
			$error("buffer occupancy above depth");
		end

endmodule

bind fifo_buf uart_rx_chk u_chk (
	.clk(clk),
	.reset(reset),
	.wr(wr),
	.wr_rdy(wr_rdy),
	.out_valid(out_valid),
	.credits(credits),
	.count(count)
);

// ==== dv/uart_rx_input.txt ====
# Columns: command byte flag; s send, h hold credits, r release credits, b frame with low stop bit
# Byte in hex; flag 1 means the sent byte is expected to be dropped with an overrun
s 55 0
s a3 0
s 00 0
s ff 0
s 01 0
s 80 0
s 7e 0
h 00 0
s 10 0
s 11 0
s 12 0
s 13 0
s 14 0
s 15 0
s 16 0
s 17 0
s 18 0
s 19 0
s 1a 0
s 1b 0
s ee 1
r 00 0
s 3c 0
s 5a 0
b 99 0
s 66 0

// ==== dv/uart_rx_tb.sv ====
`timescale 1ns/10ps

`include "uart_config.svh"

module uart_rx_tb;

	logic clk;
	logic reset;
	logic rx;
	logic credit_return;
	logic out_valid;
	uart_pkg::uart_byte_t out_data;
	logic overrun;

	// Commands from the data file, one entry per line
	byte cmd_q[$];
	uart_pkg::uart_byte_t val_q[$];
	logic flag_q[$];

	// Bytes the DUT still owes, in order
	uart_pkg::uart_byte_t expected_q[$];

	int pending_credits;
	int return_delay;
	logic credits_held;
	int overrun_pulses;
	int expected_drops;
	int cycle_count;
	int cycle_limit;

	uart_rx_subsystem UUT (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.credit_return(credit_return),
		.out_valid(out_valid),
		.out_data(out_data),
		.overrun(overrun)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input uart_pkg::uart_byte_t actual,
		input uart_pkg::uart_byte_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0t: out_data is %02h, expected %02h",
				$time, actual, expected));
		end
	endtask

	task automatic check_overrun(input logic actual, input logic expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0t: overrun seen %0b, expected %0b",
				$time, actual, expected));
		end
	endtask

	// Each wait ends 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drive_bit(input logic value);
		rx = value;
		idle_cycles(`UART_CLKS_PER_BIT);
	endtask

	// Start bit, data LSB first, stop bit
	task automatic send_frame(input uart_pkg::uart_byte_t value, input logic stop_bit);
		drive_bit(1'b0);
		for (int i = 0; i < `UART_DATA_SIZE; i++) begin
			drive_bit(value[i]);
		end
		drive_bit(stop_bit);
		// Idle long enough for the false start after a low stop bit to clear
		rx = 1'b1;
		idle_cycles(`UART_CLKS_PER_BIT + 2);
	endtask

	task automatic read_commands;
		int fd;
		string line;
		byte cmd;
		int value;
		int flag;
		int fields;
		fd = $fopen("dv/uart_rx_input.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the data file dv/uart_rx_input.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Skip blank lines and comment lines
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%c %h %d", cmd, value, flag);
					if (fields != 3) begin
						abort_run({"Malformed line in the data file: ", line});
					end else begin
						cmd_q.push_back(cmd);
						val_q.push_back(uart_pkg::uart_byte_t'(value));
						flag_q.push_back(flag[0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Watchdog for the cycle limit and the bound assertions
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			abort_run($sformatf("Timeout: the test did not finish within %0d cycles",
				cycle_limit));
		end else if (UUT.u_fifo.u_chk.failures != 0) begin
			abort_run("A handshake assertion in the buffer checker failed");
		end
	end

	// Delivered bytes against the scoreboard, each one owes a credit back
	always @(posedge clk) begin
		if (!reset && out_valid === 1'b1) begin
			if (expected_q.size() == 0) begin
				abort_run($sformatf("Byte %02h delivered at %0t while none was expected",
					out_data, $time));
			end else begin
				check_byte(out_data, expected_q.pop_front());
				pending_credits++;
			end
		end
		if (!reset && overrun === 1'b1) begin
			overrun_pulses++;
		end
	end

	// Consumer hands credits back one pulse at a time after a random delay
	initial begin
		forever begin
			@(posedge clk);
			#1;
			credit_return = 1'b0;
			if (!reset && !credits_held && pending_credits > 0) begin
				if (return_delay == 0) begin
					credit_return = 1'b1;
					pending_credits--;
					return_delay = $urandom % 4;
				end else begin
					return_delay--;
				end
			end
		end
	end

	initial begin
		int frame_count;
		int pulses_before;
		int drain;
		byte cmd;
		uart_pkg::uart_byte_t value;
		logic flag;
		void'($urandom(36));
		rx = 1'b1;
		reset = 1'b1;
		credit_return = 1'b0;
		credits_held = 1'b0;
		pending_credits = 0;
		return_delay = 0;
		overrun_pulses = 0;
		expected_drops = 0;
		cycle_count = 0;
		cycle_limit = 0;
		read_commands();
		frame_count = 0;
		foreach (cmd_q[i]) begin
			if (cmd_q[i] == "s" || cmd_q[i] == "b") begin
				frame_count++;
			end
		end
		cycle_limit = frame_count * 100 + 2000;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		while (cmd_q.size() != 0) begin
			cmd = cmd_q.pop_front();
			value = val_q.pop_front();
			flag = flag_q.pop_front();
			case (cmd)
				"s", "b": begin
					// Expected byte goes in first, delivery starts before the frame task returns
					if (cmd == "s" && !flag) begin
						expected_q.push_back(value);
					end
					if (flag) begin
						expected_drops++;
					end
					pulses_before = overrun_pulses;
					send_frame(value, cmd == "s");
					if (overrun_pulses - pulses_before > 1) begin
						abort_run("More than one overrun pulse for a single frame");
					end
					check_overrun(overrun_pulses != pulses_before, flag);
					idle_cycles($urandom % 21);
				end
				"h": begin
					// Hold starts from a full grant of credits
					while (expected_q.size() != 0 || pending_credits != 0) begin
						idle_cycles(1);
					end
					credits_held = 1'b1;
				end
				"r": begin
					credits_held = 1'b0;
				end
				default: begin
					abort_run($sformatf("Unknown command %c in the data file", cmd));
				end
			endcase
		end
		drain = 0;
		while (expected_q.size() != 0 && drain < 500) begin
			idle_cycles(1);
			drain++;
		end
		if (expected_q.size() != 0) begin
			abort_run($sformatf("%0d expected bytes were never delivered", expected_q.size()));
		end else if (overrun_pulses != expected_drops) begin
			abort_run($sformatf("Saw %0d overrun pulses in total, expected %0d",
				overrun_pulses, expected_drops));
		end else if (UUT.u_fifo.u_chk.failures != 0) begin
			abort_run($sformatf("%0d handshake assertions failed", UUT.u_fifo.u_chk.failures));
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== logic/fifo_buf.sv ====
`timescale 1ns/10ps

`include "uart_config.svh"

module fifo_buf (
	input logic clk,
	input logic reset,
	input uart_pkg::fifo_wr_t wr,
	output logic wr_rdy,
	output logic wr_done,
	output logic is_full,
	input logic credit_return,
	output logic out_valid,
	output uart_pkg::uart_byte_t out_data
);

	uart_pkg::uart_byte_t mem [`UART_FIFO_DEPTH];

	uart_pkg::fifo_ptr_t wr_ptr;
	uart_pkg::fifo_ptr_t rd_ptr;
	uart_pkg::fifo_cnt_t count;
	uart_pkg::credit_cnt_t credits;

	// Write request latched for one cycle before the commit
	logic wr_pend;
	uart_pkg::uart_byte_t wr_data_q;

	logic do_write;
	logic do_read;

	// Pointer advance with wrap at the configured depth
	function automatic uart_pkg::fifo_ptr_t next_ptr(input uart_pkg::fifo_ptr_t ptr);
		if (ptr == uart_pkg::fifo_ptr_t'(`UART_FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign is_full = (count == uart_pkg::fifo_cnt_t'(`UART_FIFO_DEPTH));

	// Sequencer is busy only in the commit cycle
	assign wr_rdy = !wr_pend;
	assign wr_done = wr_pend;

	// Bridge tests is_full before it requests a write
	assign do_write = wr_pend;

	// Send whenever there is data and the consumer has granted room
	assign out_valid = (count != '0) && (credits != '0);
	assign do_read = out_valid;
	assign out_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= wr.trigger && wr_rdy;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.trigger && wr_rdy) begin
			wr_data_q <= wr.data;
		end
		if (do_write) begin
			mem[wr_ptr] <= wr_data_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= uart_pkg::credit_cnt_t'(`UART_OUT_CREDITS);
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Simultaneous write and read leave the occupancy unchanged
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// One credit spent per byte sent, one gained per return pulse
			case ({credit_return, do_read})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// ==== logic/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Serial bit timing
// Clock cycles per serial bit, round(clk_freq / baud rate)
// Kept small so simulation frames stay short
`define UART_CLKS_PER_BIT 8

// Width of the bit-time counter, clog2 of UART_CLKS_PER_BIT
`define UART_COUNTER_BITS 3

// Frame payload
// Data bits per frame, start and stop bits not counted
`define UART_DATA_SIZE 8

// Width of the bit index inside a frame, clog2 of UART_DATA_SIZE
`define UART_DATA_SIZE_BITS 3

// Byte buffer
// Number of byte entries in the circular buffer
`define UART_FIFO_DEPTH 8

// Consumer flow control
// Credits the consumer grants right after reset
`define UART_OUT_CREDITS 4

`endif

// ==== logic/uart_pkg.sv ====
`include "uart_config.svh"

package uart_pkg;

	// One received data byte
	typedef logic [`UART_DATA_SIZE-1:0] uart_byte_t;

	// Read or write index into the byte buffer
	typedef logic [$clog2(`UART_FIFO_DEPTH)-1:0] fifo_ptr_t;

	// Buffer occupancy, 0 up to and including the depth
	typedef logic [$clog2(`UART_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

	// Credits currently held by the buffer read side
	typedef logic [$clog2(`UART_OUT_CREDITS+1)-1:0] credit_cnt_t;

	// Serial receiver states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Buffer write sequencer states
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_REQUEST,
		WR_WAIT_DONE
	} wr_state_e;

	// Write request from the bridge into the buffer
	typedef struct packed {
		logic trigger;
		uart_byte_t data;
	} fifo_wr_t;

endpackage

// ==== logic/uart_rx_controller.sv ====
`timescale 1ns/10ps

`include "uart_config.svh"

module uart_rx_controller (
	input logic clk,
	input logic reset,
	input logic rx,
	output uart_pkg::uart_byte_t data,
	output logic rx_done
);

	// Two-flop synchronizer for the asynchronous serial line
	logic rx_meta;
	logic rx_sync;

	uart_pkg::rx_state_e state;
	logic [`UART_COUNTER_BITS-1:0] clk_cnt;
	logic [`UART_DATA_SIZE_BITS-1:0] bit_idx;

	// Full bit time elapsed, used for data and stop sampling
	logic bit_tick;
	// Half bit time elapsed, used to land on mid-start
	logic half_tick;

	assign bit_tick = (clk_cnt == `UART_COUNTER_BITS'(`UART_CLKS_PER_BIT - 1));
	assign half_tick = (clk_cnt == `UART_COUNTER_BITS'(`UART_CLKS_PER_BIT / 2 - 1));

	// Line idles high, so the synchronizer resets to one
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_done <= 1'b0;
		end else begin
			// Done is a single-cycle pulse
			rx_done <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				uart_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					// Falling edge marks a possible start bit
					if (!rx_sync) begin
						state <= uart_pkg::RX_START;
					end
				end
				uart_pkg::RX_START: begin
					if (half_tick) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// Line back high at mid-start is a glitch, not a frame
						if (!rx_sync) begin
							state <= uart_pkg::RX_DATA;
						end else begin
							state <= uart_pkg::RX_IDLE;
						end
					end
				end
				uart_pkg::RX_DATA: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == `UART_DATA_SIZE_BITS'(`UART_DATA_SIZE - 1)) begin
							state <= uart_pkg::RX_STOP;
						end
					end
				end
				uart_pkg::RX_STOP: begin
					if (bit_tick) begin
						// A low stop bit drops the frame silently
						rx_done <= rx_sync;
						state <= uart_pkg::RX_IDLE;
					end
				end
				default: begin
					state <= uart_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// Shift register, LSB arrives first so bits enter at the top
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && bit_tick) begin
			data <= {rx_sync, data[`UART_DATA_SIZE-1:1]};
		end
	end

endmodule

// ==== logic/uart_rx_subsystem.sv ====
`timescale 1ns/10ps

module uart_rx_subsystem (
	input logic clk,
	input logic reset,
	input logic rx,
	input logic credit_return,
	output logic out_valid,
	output uart_pkg::uart_byte_t out_data,
	output logic overrun
);

	// Write port between the bridge and the buffer
	uart_pkg::fifo_wr_t wr;
	logic wr_rdy;
	logic wr_done;
	logic is_full;

	// Serial receive side with the write sequencer
	uart_to_fifo_buf u_bridge (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.wr_done(wr_done),
		.wr_rdy(wr_rdy),
		.is_full(is_full),
		.wr(wr),
		.overrun(overrun)
	);

	// Byte storage and credit-gated delivery
	fifo_buf u_fifo (
		.clk(clk),
		.reset(reset),
		.wr(wr),
		.wr_rdy(wr_rdy),
		.wr_done(wr_done),
		.is_full(is_full),
		.credit_return(credit_return),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

// ==== logic/uart_to_fifo_buf.sv ====
`timescale 1ns/10ps

module uart_to_fifo_buf (
	input logic clk,
	input logic reset,
	input logic rx,
	input logic wr_done,
	input logic wr_rdy,
	input logic is_full,
	output uart_pkg::fifo_wr_t wr,
	output logic overrun
);

	uart_pkg::uart_byte_t rx_data;
	logic rx_done;
	logic store;
	logic wr_trigger;

	// Holding register frees the receiver for the next frame
	uart_pkg::uart_byte_t held_data;

	uart_rx_controller u_rx (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.data(rx_data),
		.rx_done(rx_done)
	);

	uart_to_fifo_buf_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.rx_done(rx_done),
		.wr_done(wr_done),
		.wr_rdy(wr_rdy),
		.is_full(is_full),
		.store(store),
		.wr_trigger(wr_trigger),
		.overrun(overrun)
	);

	always_ff @(posedge clk) begin
		if (store) begin
			held_data <= rx_data;
		end
	end

	assign wr.trigger = wr_trigger;
	assign wr.data = held_data;

endmodule

// ==== logic/uart_to_fifo_buf_fsm.sv ====
`timescale 1ns/10ps

module uart_to_fifo_buf_fsm (
	input logic clk,
	input logic reset,
	input logic rx_done,
	input logic wr_done,
	input logic wr_rdy,
	input logic is_full,
	output logic store,
	output logic wr_trigger,
	output logic overrun
);

	uart_pkg::wr_state_e state;
	uart_pkg::wr_state_e state_next;

	// Accept a byte only when idle and the buffer has room
	assign store = rx_done && (state == uart_pkg::WR_IDLE) && !is_full;

	// Any other arrival is lost
	// Busy case is unreachable at the configured bit timing
	assign overrun = rx_done && ((state != uart_pkg::WR_IDLE) || is_full);

	// Trigger lasts one cycle since the state leaves request right away
	assign wr_trigger = (state == uart_pkg::WR_REQUEST) && wr_rdy;

	always_comb begin
		state_next = state;
		case (state)
			uart_pkg::WR_IDLE: begin
				if (store) begin
					state_next = uart_pkg::WR_REQUEST;
				end
			end
			uart_pkg::WR_REQUEST: begin
				// Wait here while the buffer is still committing
				if (wr_rdy) begin
					state_next = uart_pkg::WR_WAIT_DONE;
				end
			end
			uart_pkg::WR_WAIT_DONE: begin
				if (wr_done) begin
					state_next = uart_pkg::WR_IDLE;
				end
			end
			default: begin
				state_next = uart_pkg::WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uart_pkg::WR_IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

// ==== uart_rx_subsystem.f ====
+incdir+logic
logic/uart_pkg.sv
logic/uart_rx_controller.sv
logic/uart_to_fifo_buf_fsm.sv
logic/uart_to_fifo_buf.sv
logic/fifo_buf.sv
logic/uart_rx_subsystem.sv
dv/uart_rx_chk.sv
dv/uart_rx_tb.sv
